/* hdl/saturn_dec_pkg.sv */
// saturn decoder package: alu operations, decode blocks, per-nibble decode result, opcodes
package saturn_dec_pkg;

  // datapath widths
  localparam int nibble_w         = 4;
  localparam int addr_w           = 20;
  localparam int max_load_nibbles = 16;
  localparam int load_w           = nibble_w * max_load_nibbles;
  localparam int count_w          = 5;

  // operation handed to the execute stage
  typedef enum logic [4:0] {
    alu_none     = 5'd0,
    alu_copy,
    alu_exch,
    alu_zero,
    alu_inc,
    alu_dec,
    alu_add,
    alu_neg,
    alu_jmp_rel2,
    alu_jmp_rel3
  } alu_op_t;

  // owner of the next nibble, idle means a first nibble is expected
  typedef enum logic [2:0] {
    blk_idle     = 3'd0,
    blk_0x,
    blk_2x,
    blk_lc_count,
    blk_imm,
    blk_cx,
    blk_dx,
    blk_fx
  } block_t;

  // one peer decoder's verdict, all zero when the decoder does not claim
  typedef struct packed {
    logic                hit;
    logic                done;
    logic                error;
    block_t              next_block;
    alu_op_t             alu_op;
    logic                ins_alu_op;
    logic                rtn;
    logic                push;
    logic                pop;
    logic                set_xm;
    logic                set_carry;
    logic                carry_val;
    logic                set_mode;
    logic                mode_dec;
    logic [nibble_w-1:0] imm;
  } dec_result_t;

  // first nibbles kept by this decoder
  localparam logic [nibble_w-1:0] op_grp_0 = 4'h0;
  localparam logic [nibble_w-1:0] op_grp_2 = 4'h2;
  localparam logic [nibble_w-1:0] op_grp_3 = 4'h3;
  localparam logic [nibble_w-1:0] op_goc   = 4'h4;
  localparam logic [nibble_w-1:0] op_gonc  = 4'h5;
  localparam logic [nibble_w-1:0] op_goto  = 4'h6;
  localparam logic [nibble_w-1:0] op_gosub = 4'h7;
  localparam logic [nibble_w-1:0] op_grp_c = 4'hC;
  localparam logic [nibble_w-1:0] op_grp_d = 4'hD;
  localparam logic [nibble_w-1:0] op_grp_f = 4'hF;

endpackage

/* hdl/nibble_bus_if.sv */
// nibble bus: accepted nibble, current block and dispatched alu op, sequencer to peer decoders
`timescale 1ns/10ps

interface nibble_bus_if;
  import saturn_dec_pkg::*;

  // high in a cycle where the decoder accepts the nibble
  logic                take;
  logic [nibble_w-1:0] nibble;
  // block that owns this nibble
  block_t              block;
  // op set at dispatch, jump kind for the immediate loader
  alu_op_t             alu_op;

  modport src (
    output take,
    output nibble,
    output block,
    output alu_op
  );

  modport dec (
    input take,
    input nibble,
    input block,
    input alu_op
  );

endinterface

/* hdl/decode_sequencer.sv */
// decode sequencer: first-nibble dispatch, block state and registered decode results
`timescale 1ns/10ps

module decode_sequencer (
  input  logic                                i_clk,
  input  logic                                i_reset,
  input  logic                                i_en_dec,
  input  logic                                i_stalled,
  input  logic [saturn_dec_pkg::addr_w-1:0]   i_pc,
  input  logic [saturn_dec_pkg::nibble_w-1:0] i_nibble,
  nibble_bus_if.src                           bus,
  input  saturn_dec_pkg::dec_result_t         i_sys_res,
  input  saturn_dec_pkg::dec_result_t         i_reg_res,
  input  saturn_dec_pkg::dec_result_t         i_imm_res,
  output logic                                o_ins_decoded,
  output logic                                o_dec_error,
  output logic [saturn_dec_pkg::addr_w-1:0]   o_ins_addr,
  output saturn_dec_pkg::alu_op_t             o_alu_op,
  output logic                                o_ins_alu_op,
  output logic                                o_ins_rtn,
  output logic                                o_push,
  output logic                                o_pop,
  output logic                                o_set_xm,
  output logic                                o_set_carry,
  output logic                                o_carry_val,
  output logic                                o_test_carry,
  output logic                                o_ins_set_mode,
  output logic                                o_mode_dec,
  output logic [saturn_dec_pkg::nibble_w-1:0] o_imm_value
);
  import saturn_dec_pkg::*;

  logic        take;
  logic        first;
  block_t      block;
  dec_result_t merged;

  // nibble accepted this cycle
  assign take  = i_en_dec && !i_stalled;
  // idle block means this is an opcode's first nibble
  assign first = take && (block == blk_idle);
  // at most one peer hits, the rest drive zeros
  assign merged = i_sys_res | i_reg_res | i_imm_res;

  assign bus.take   = take;
  assign bus.nibble = i_nibble;
  assign bus.block  = block;
  assign bus.alu_op = o_alu_op;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      block          <= blk_idle;
      o_ins_decoded  <= 1'b0;
      o_dec_error    <= 1'b0;
      o_alu_op       <= alu_none;
      o_ins_alu_op   <= 1'b0;
      o_ins_rtn      <= 1'b0;
      o_push         <= 1'b0;
      o_pop          <= 1'b0;
      o_set_xm       <= 1'b0;
      o_set_carry    <= 1'b0;
      o_carry_val    <= 1'b0;
      o_test_carry   <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
    end else begin
      // pulses last one cycle
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
      if (first) begin
        // new instruction, drop the old results
        o_alu_op       <= alu_none;
        o_ins_alu_op   <= 1'b0;
        o_ins_rtn      <= 1'b0;
        o_push         <= 1'b0;
        o_pop          <= 1'b0;
        o_set_xm       <= 1'b0;
        o_set_carry    <= 1'b0;
        o_carry_val    <= 1'b0;
        o_test_carry   <= 1'b0;
        o_ins_set_mode <= 1'b0;
        o_mode_dec     <= 1'b0;
        case (i_nibble)
          op_grp_0: block <= blk_0x;
          op_grp_2: block <= blk_2x;
          op_grp_3: block <= blk_lc_count;
          op_goc, op_gonc: begin
            // goc / gonc, two offset nibbles
            block        <= blk_imm;
            o_alu_op     <= alu_jmp_rel2;
            o_test_carry <= 1'b1;
            o_carry_val  <= (i_nibble == op_goc);
          end
          op_goto, op_gosub: begin
            // goto / gosub, three offset nibbles
            block    <= blk_imm;
            o_alu_op <= alu_jmp_rel3;
            o_push   <= (i_nibble == op_gosub);
          end
          op_grp_c: block <= blk_cx;
          op_grp_d: block <= blk_dx;
          op_grp_f: block <= blk_fx;
          default: begin
            // dropped or unknown group
            block       <= blk_idle;
            o_dec_error <= 1'b1;
          end
        endcase
      end else if (take && merged.hit) begin
        // flags accumulate over the instruction
        o_ins_alu_op   <= o_ins_alu_op | merged.ins_alu_op;
        o_ins_rtn      <= o_ins_rtn | merged.rtn;
        o_push         <= o_push | merged.push;
        o_pop          <= o_pop | merged.pop;
        o_set_xm       <= o_set_xm | merged.set_xm;
        o_set_carry    <= o_set_carry | merged.set_carry;
        o_carry_val    <= o_carry_val | merged.carry_val;
        o_ins_set_mode <= o_ins_set_mode | merged.set_mode;
        o_mode_dec     <= o_mode_dec | merged.mode_dec;
        // dispatched op stays unless a peer names one
        if (merged.alu_op != alu_none) begin
          o_alu_op <= merged.alu_op;
        end
        block         <= merged.next_block;
        o_ins_decoded <= merged.done;
        o_dec_error   <= merged.error;
      end
    end
  end

  // instruction address and immediate nibble
  always_ff @(posedge i_clk) begin
    if (first) begin
      o_ins_addr  <= i_pc;
      o_imm_value <= '0;
    end else if (take && merged.hit) begin
      o_imm_value <= merged.imm;
    end
  end

endmodule

/* hdl/system_op_decode.sv */
// 0x group decoder: returns, hex/dec mode, rstk copies, status ops and p inc/dec
`timescale 1ns/10ps

module system_op_decode (
  nibble_bus_if.dec                   bus,
  output saturn_dec_pkg::dec_result_t o_res
);
  import saturn_dec_pkg::*;

  always_comb begin
    o_res = '0;
    if (bus.take && (bus.block == blk_0x)) begin
      o_res.hit        = 1'b1;
      o_res.done       = 1'b1;
      o_res.next_block = blk_idle;
      case (bus.nibble)
        4'h0, 4'h1, 4'h2, 4'h3: begin
          // rtnsxm, rtn, rtnsc, rtncc
          o_res.rtn       = 1'b1;
          o_res.pop       = 1'b1;
          o_res.set_xm    = (bus.nibble == 4'h0);
          o_res.set_carry = bus.nibble[1];
          o_res.carry_val = (bus.nibble == 4'h2);
        end
        4'h4, 4'h5: begin
          // sethex / setdec
          o_res.set_mode = 1'b1;
          o_res.mode_dec = bus.nibble[0];
        end
        4'h6, 4'h7: begin
          // rstk=c pushes, c=rstk pops
          o_res.ins_alu_op = 1'b1;
          o_res.alu_op     = alu_copy;
          o_res.push       = !bus.nibble[0];
          o_res.pop        = bus.nibble[0];
        end
        4'h8: begin
          // clrst
          o_res.ins_alu_op = 1'b1;
          o_res.alu_op     = alu_zero;
        end
        4'h9, 4'hA: begin
          // c=st, st=c
          o_res.ins_alu_op = 1'b1;
          o_res.alu_op     = alu_copy;
        end
        4'hB: begin
          o_res.ins_alu_op = 1'b1;
          o_res.alu_op     = alu_exch;
        end
        4'hC, 4'hD: begin
          // p=p+1 / p=p-1
          o_res.ins_alu_op = 1'b1;
          o_res.alu_op     = bus.nibble[0] ? alu_dec : alu_inc;
        end
        default: begin
          // 0e and/or group and rti are not decoded
          o_res.done  = 1'b0;
          o_res.error = 1'b1;
        end
      endcase
    end
  end

endmodule

/* hdl/register_op_decode.sv */
// register group decoder for p=n, cx add/dec, dx copy/exch and fx negate
`timescale 1ns/10ps

module register_op_decode (
  nibble_bus_if.dec                   bus,
  output saturn_dec_pkg::dec_result_t o_res
);
  import saturn_dec_pkg::*;

  logic owned;
  // upper quarter of cx / dx switches the op
  logic upper;

  assign owned = (bus.block == blk_2x) || (bus.block == blk_cx) ||
                 (bus.block == blk_dx) || (bus.block == blk_fx);
  assign upper = (bus.nibble[3:2] == 2'b11);

  always_comb begin
    o_res = '0;
    if (bus.take && owned) begin
      o_res.hit        = 1'b1;
      o_res.next_block = blk_idle;
      // register select or p value for the next stage
      o_res.imm        = bus.nibble;
      o_res.ins_alu_op = 1'b1;
      o_res.done       = 1'b1;
      case (bus.block)
        blk_2x: o_res.alu_op = alu_copy;
        blk_cx: o_res.alu_op = upper ? alu_dec : alu_add;
        blk_dx: o_res.alu_op = upper ? alu_exch : alu_copy;
        default: begin
          // fx, only f8..fb are negates
          if (bus.nibble[3:2] == 2'b10) begin
            o_res.alu_op = alu_neg;
          end else begin
            o_res.ins_alu_op = 1'b0;
            o_res.done       = 1'b0;
            o_res.error      = 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/immediate_loader.sv */
// immediate loader: collects 3n load nibbles and relative jump offsets
`timescale 1ns/10ps

module immediate_loader (
  input  logic                               i_clk,
  input  logic                               i_reset,
  nibble_bus_if.dec                          bus,
  output saturn_dec_pkg::dec_result_t        o_res,
  output logic [saturn_dec_pkg::load_w-1:0]  o_load_value,
  output logic [saturn_dec_pkg::count_w-1:0] o_load_count
);
  import saturn_dec_pkg::*;

  logic [count_w-1:0] pos;
  logic [count_w-1:0] target;
  logic               have_count;
  logic [count_w-1:0] cur_pos;
  logic [count_w-1:0] cur_target;
  logic               in_count;
  logic               in_imm;
  logic               last;

  assign in_count = bus.take && (bus.block == blk_lc_count);
  assign in_imm   = bus.take && (bus.block == blk_imm);

  // jumps arrive without a stored count, start from zero
  assign cur_pos = have_count ? pos : '0;

  always_comb begin
    if (have_count) begin
      cur_target = target;
    end else if (bus.alu_op == alu_jmp_rel3) begin
      cur_target = count_w'(3);
    end else begin
      cur_target = count_w'(2);
    end
  end

  assign last = ((cur_pos + 1'b1) == cur_target);
  assign o_load_count = pos;

  always_comb begin
    o_res = '0;
    if (in_count) begin
      // 3n: load c with n+1 nibbles
      o_res.hit        = 1'b1;
      o_res.alu_op     = alu_copy;
      o_res.ins_alu_op = 1'b1;
      o_res.next_block = blk_imm;
    end else if (in_imm) begin
      o_res.hit        = 1'b1;
      o_res.imm        = bus.nibble;
      o_res.done       = last;
      o_res.next_block = last ? blk_idle : blk_imm;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pos        <= '0;
      target     <= '0;
      have_count <= 1'b0;
    end else if (in_count) begin
      target     <= count_w'(bus.nibble) + 1'b1;
      pos        <= '0;
      have_count <= 1'b1;
    end else if (in_imm) begin
      // pos ends at the nibble count
      pos        <= cur_pos + 1'b1;
      target     <= cur_target;
      have_count <= !last;
    end
  end

  // nibbles packed low to high in arrival order
  always_ff @(posedge i_clk) begin
    if (in_count) begin
      o_load_value <= '0;
    end else if (in_imm) begin
      if (!have_count) begin
        o_load_value <= load_w'(bus.nibble);
      end else begin
        o_load_value[cur_pos*nibble_w +: nibble_w] <= bus.nibble;
      end
    end
  end

endmodule

/* hdl/saturn_decoder_top.sv */
// saturn nibble decoder top: sequencer plus three peer decoders on a shared nibble bus
`timescale 1ns/10ps

module saturn_decoder_top (
  input  logic                                i_clk,
  input  logic                                i_reset,
  input  logic                                i_en_dec,
  input  logic                                i_stalled,
  input  logic [saturn_dec_pkg::addr_w-1:0]   i_pc,
  input  logic [saturn_dec_pkg::nibble_w-1:0] i_nibble,
  output logic                                o_ins_decoded,
  output logic                                o_dec_error,
  output logic [saturn_dec_pkg::addr_w-1:0]   o_ins_addr,
  output saturn_dec_pkg::alu_op_t             o_alu_op,
  output logic                                o_ins_alu_op,
  output logic                                o_ins_rtn,
  output logic                                o_push,
  output logic                                o_pop,
  output logic                                o_set_xm,
  output logic                                o_set_carry,
  output logic                                o_carry_val,
  output logic                                o_test_carry,
  output logic                                o_ins_set_mode,
  output logic                                o_mode_dec,
  output logic [saturn_dec_pkg::nibble_w-1:0] o_imm_value,
  output logic [saturn_dec_pkg::load_w-1:0]   o_load_value,
  output logic [saturn_dec_pkg::count_w-1:0]  o_load_count
);
  import saturn_dec_pkg::*;

  // per-decoder verdicts back to the sequencer
  dec_result_t sys_res;
  dec_result_t reg_res;
  dec_result_t imm_res;

  nibble_bus_if nib_bus ();

  decode_sequencer seq_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_en_dec       (i_en_dec),
    .i_stalled      (i_stalled),
    .i_pc           (i_pc),
    .i_nibble       (i_nibble),
    .bus            (nib_bus.src),
    .i_sys_res      (sys_res),
    .i_reg_res      (reg_res),
    .i_imm_res      (imm_res),
    .o_ins_decoded  (o_ins_decoded),
    .o_dec_error    (o_dec_error),
    .o_ins_addr     (o_ins_addr),
    .o_alu_op       (o_alu_op),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_ins_rtn      (o_ins_rtn),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_test_carry   (o_test_carry),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec),
    .o_imm_value    (o_imm_value)
  );

  // 0x group
  system_op_decode sys_dec_i (
    .bus   (nib_bus.dec),
    .o_res (sys_res)
  );

  // 2n, cx, dx, fx groups
  register_op_decode reg_dec_i (
    .bus   (nib_bus.dec),
    .o_res (reg_res)
  );

  // 3n loads and jump offsets
  immediate_loader imm_ld_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .bus          (nib_bus.dec),
    .o_res        (imm_res),
    .o_load_value (o_load_value),
    .o_load_count (o_load_count)
  );

endmodule

/* testbench/saturn_decoder_assertions.sv */
// decode sequencer checks: pulse exclusion, single peer hit, quiet pulses after reset
`timescale 1ns/10ps

module saturn_decoder_assertions (
  input logic                        i_clk,
  input logic                        i_reset,
  input logic                        i_take,
  input logic                        i_ins_decoded,
  input logic                        i_dec_error,
  input saturn_dec_pkg::dec_result_t i_sys_res,
  input saturn_dec_pkg::dec_result_t i_reg_res,
  input saturn_dec_pkg::dec_result_t i_imm_res
);
  // high once a nibble has been taken since reset
  logic seen_take;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      seen_take <= 1'b0;
    end else if (i_take) begin
      seen_take <= 1'b1;
    end
  end

  pulse_excl: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_ins_decoded && i_dec_error))
    else $error("decoded and error pulses high in the same cycle");

  // peers own disjoint blocks
  single_hit: assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({i_sys_res.hit, i_reg_res.hit, i_imm_res.hit}))
    else $error("more than one peer decoder claimed the nibble");

  quiet_after_reset: assert property (@(posedge i_clk) disable iff (i_reset)
    !seen_take |-> (!i_ins_decoded && !i_dec_error))
    else $error("pulse before any nibble was taken after reset");

endmodule

bind decode_sequencer saturn_decoder_assertions asrt_i (
  .i_clk         (i_clk),
  .i_reset       (i_reset),
  .i_take        (take),
  .i_ins_decoded (o_ins_decoded),
  .i_dec_error   (o_dec_error),
  .i_sys_res     (i_sys_res),
  .i_reg_res     (i_reg_res),
  .i_imm_res     (i_imm_res)
);

/* testbench/saturn_decoder_tb.sv */
// saturn decoder testbench: instruction table with random stalls, checked every cycle
`timescale 1ns/10ps

module saturn_decoder_tb;
  import saturn_dec_pkg::*;

  // expected flag vector, msb first
  localparam logic [9:0] fl_ins  = 10'h200;
  localparam logic [9:0] fl_rtn  = 10'h100;
  localparam logic [9:0] fl_push = 10'h080;
  localparam logic [9:0] fl_pop  = 10'h040;
  localparam logic [9:0] fl_xm   = 10'h020;
  localparam logic [9:0] fl_sc   = 10'h010;
  localparam logic [9:0] fl_cv   = 10'h008;
  localparam logic [9:0] fl_tc   = 10'h004;
  localparam logic [9:0] fl_mode = 10'h002;
  localparam logic [9:0] fl_dec  = 10'h001;

  // one instruction, nibble 0 in the low bits
  typedef struct packed {
    logic [79:0]         nibs;
    int                  len;
    logic [addr_w-1:0]   pc;
    alu_op_t             op;
    logic [9:0]          flags;
    logic [nibble_w-1:0] imm;
    logic                err;
    logic                chk_load;
    logic [load_w-1:0]   load_value;
    logic [count_w-1:0]  load_count;
  } ins_entry_t;

  logic                i_clk;
  logic                i_reset = 1'b1;
  logic                i_en_dec = 1'b0;
  logic                i_stalled = 1'b0;
  logic [addr_w-1:0]   i_pc = '0;
  logic [nibble_w-1:0] i_nibble = '0;
  logic                o_ins_decoded;
  logic                o_dec_error;
  logic [addr_w-1:0]   o_ins_addr;
  alu_op_t             o_alu_op;
  logic                o_ins_alu_op;
  logic                o_ins_rtn;
  logic                o_push;
  logic                o_pop;
  logic                o_set_xm;
  logic                o_set_carry;
  logic                o_carry_val;
  logic                o_test_carry;
  logic                o_ins_set_mode;
  logic                o_mode_dec;
  logic [nibble_w-1:0] o_imm_value;
  logic [load_w-1:0]   o_load_value;
  logic [count_w-1:0]  o_load_count;

  // values for the next rising edge
  logic                drv_reset = 1'b1;
  logic                drv_en = 1'b0;
  logic                drv_stall = 1'b0;
  logic [addr_w-1:0]   drv_pc = '0;
  logic [nibble_w-1:0] drv_nibble = '0;

  ins_entry_t table_q[$];
  logic       table_ready = 1'b0;
  int         seed = 32'h7308;
  // entry whose last nibble is on the inputs
  int         pend_idx = -1;

  saturn_decoder_top dut_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_en_dec       (i_en_dec),
    .i_stalled      (i_stalled),
    .i_pc           (i_pc),
    .i_nibble       (i_nibble),
    .o_ins_decoded  (o_ins_decoded),
    .o_dec_error    (o_dec_error),
    .o_ins_addr     (o_ins_addr),
    .o_alu_op       (o_alu_op),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_ins_rtn      (o_ins_rtn),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_test_carry   (o_test_carry),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec),
    .o_imm_value    (o_imm_value),
    .o_load_value   (o_load_value),
    .o_load_count   (o_load_count)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // inputs change only on the rising edge
  always @(posedge i_clk) begin
    i_reset   <= drv_reset;
    i_en_dec  <= drv_en;
    i_stalled <= drv_stall;
    i_pc      <= drv_pc;
    i_nibble  <= drv_nibble;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_op(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %s, expected %s",
                          $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic compare_flags(input logic [9:0] exp);
    check_flag("o_ins_alu_op", o_ins_alu_op, exp[9]);
    check_flag("o_ins_rtn", o_ins_rtn, exp[8]);
    check_flag("o_push", o_push, exp[7]);
    check_flag("o_pop", o_pop, exp[6]);
    check_flag("o_set_xm", o_set_xm, exp[5]);
    check_flag("o_set_carry", o_set_carry, exp[4]);
    check_flag("o_carry_val", o_carry_val, exp[3]);
    check_flag("o_test_carry", o_test_carry, exp[2]);
    check_flag("o_ins_set_mode", o_ins_set_mode, exp[1]);
    check_flag("o_mode_dec", o_mode_dec, exp[0]);
  endtask

  task automatic expect_no_pulse();
    check_flag("o_ins_decoded", o_ins_decoded, 1'b0);
    check_flag("o_dec_error", o_dec_error, 1'b0);
  endtask

  task automatic compare_result(input int idx);
    ins_entry_t e;
    e = table_q[idx];
    check_flag("o_ins_decoded", o_ins_decoded, !e.err);
    check_flag("o_dec_error", o_dec_error, e.err);
    check_word("o_ins_addr", 64'(o_ins_addr), 64'(e.pc));
    check_op("o_alu_op", o_alu_op, e.op);
    compare_flags(e.flags);
    check_word("o_imm_value", 64'(o_imm_value), 64'(e.imm));
    // load outputs hold over other instructions
    if (e.chk_load) begin
      check_word("o_load_value", o_load_value, e.load_value);
      check_word("o_load_count", 64'(o_load_count), 64'(e.load_count));
    end
  endtask

  task automatic append_entry(input logic [79:0] nibs, input int len, input alu_op_t op,
                              input logic [9:0] flags, input logic [3:0] imm, input logic err,
                              input logic chk_load, input logic [63:0] lv, input int lc);
    ins_entry_t e;
    e.nibs       = nibs;
    e.len        = len;
    e.pc         = addr_w'($random(seed));
    e.op         = op;
    e.flags      = flags;
    e.imm        = imm;
    e.err        = err;
    e.chk_load   = chk_load;
    e.load_value = lv;
    e.load_count = count_w'(lc);
    table_q.push_back(e);
  endtask

  task automatic short_entry(input logic [3:0] n1, input logic [3:0] n2, input alu_op_t op,
                             input logic [9:0] flags, input logic [3:0] imm, input logic err);
    append_entry({72'h0, n2, n1}, 2, op, flags, imm, err, 1'b0, '0, 0);
  endtask

  // 3n loads and relative jumps with random digits
  task automatic immediate_entry(input logic [3:0] first, input int n);
    logic [79:0] nibs;
    logic [63:0] lv;
    logic [3:0]  d;
    logic [9:0]  flags;
    alu_op_t     op;
    int          cnt;
    int          base;
    int          k;
    nibs  = {76'h0, first};
    lv    = '0;
    d     = 4'h0;
    base  = 1;
    flags = 10'h0;
    if (first == 4'h3) begin
      nibs[7:4] = n[3:0];
      base      = 2;
      cnt       = n + 1;
      op        = alu_copy;
      flags     = fl_ins;
    end else begin
      cnt = (first >= 4'h6) ? 3 : 2;
      op  = (cnt == 3) ? alu_jmp_rel3 : alu_jmp_rel2;
      case (first)
        4'h4: flags = fl_tc | fl_cv;
        4'h5: flags = fl_tc;
        4'h7: flags = fl_push;
        default: flags = 10'h0;
      endcase
    end
    for (k = 0; k < cnt; k++) begin
      d = 4'($random(seed));
      nibs[(base + k) * 4 +: 4] = d;
      lv[k * 4 +: 4] = d;
    end
    append_entry(nibs, base + cnt, op, flags, d, 1'b0, 1'b1, lv, cnt);
  endtask

  task automatic build_table();
    logic [3:0] bad_first [6];
    int         k;
    bad_first = '{4'h1, 4'h8, 4'h9, 4'hA, 4'hB, 4'hE};
    // 0x group, every second nibble
    short_entry(4'h0, 4'h0, alu_none, fl_rtn | fl_pop | fl_xm, 4'h0, 1'b0);
    short_entry(4'h0, 4'h1, alu_none, fl_rtn | fl_pop, 4'h0, 1'b0);
    short_entry(4'h0, 4'h2, alu_none, fl_rtn | fl_pop | fl_sc | fl_cv, 4'h0, 1'b0);
    short_entry(4'h0, 4'h3, alu_none, fl_rtn | fl_pop | fl_sc, 4'h0, 1'b0);
    short_entry(4'h0, 4'h4, alu_none, fl_mode, 4'h0, 1'b0);
    short_entry(4'h0, 4'h5, alu_none, fl_mode | fl_dec, 4'h0, 1'b0);
    short_entry(4'h0, 4'h6, alu_copy, fl_ins | fl_push, 4'h0, 1'b0);
    short_entry(4'h0, 4'h7, alu_copy, fl_ins | fl_pop, 4'h0, 1'b0);
    short_entry(4'h0, 4'h8, alu_zero, fl_ins, 4'h0, 1'b0);
    short_entry(4'h0, 4'h9, alu_copy, fl_ins, 4'h0, 1'b0);
    short_entry(4'h0, 4'hA, alu_copy, fl_ins, 4'h0, 1'b0);
    short_entry(4'h0, 4'hB, alu_exch, fl_ins, 4'h0, 1'b0);
    short_entry(4'h0, 4'hC, alu_inc, fl_ins, 4'h0, 1'b0);
    short_entry(4'h0, 4'hD, alu_dec, fl_ins, 4'h0, 1'b0);
    short_entry(4'h0, 4'hE, alu_none, 10'h0, 4'h0, 1'b1);
    short_entry(4'h0, 4'hF, alu_none, 10'h0, 4'h0, 1'b1);
    // p=n and register groups, imm carries the second nibble
    short_entry(4'h2, 4'h5, alu_copy, fl_ins, 4'h5, 1'b0);
    short_entry(4'hC, 4'h3, alu_add, fl_ins, 4'h3, 1'b0);
    short_entry(4'hC, 4'hD, alu_dec, fl_ins, 4'hD, 1'b0);
    short_entry(4'hD, 4'h6, alu_copy, fl_ins, 4'h6, 1'b0);
    short_entry(4'hD, 4'hF, alu_exch, fl_ins, 4'hF, 1'b0);
    for (k = 8; k < 12; k++) begin
      short_entry(4'hF, 4'(k), alu_neg, fl_ins, 4'(k), 1'b0);
    end
    short_entry(4'hF, 4'h0, alu_none, 10'h0, 4'h0, 1'b1);
    short_entry(4'hF, 4'hE, alu_none, 10'h0, 4'hE, 1'b1);
    // rejected first nibbles
    foreach (bad_first[i]) begin
      append_entry({76'h0, bad_first[i]}, 1, alu_none, 10'h0, 4'h0, 1'b1, 1'b0, '0, 0);
    end
    immediate_entry(4'h3, 0);
    immediate_entry(4'h3, 5);
    immediate_entry(4'h3, 15);
    for (k = 4; k < 8; k++) begin
      immediate_entry(4'(k), 0);
    end
  endtask

  // one clock: set next inputs, then check outputs at the falling edge
  task automatic clock_step(input logic en, input logic stall, input logic [3:0] nib,
                            input logic [addr_w-1:0] pc, input int last_idx);
    int due;
    due        = pend_idx;
    pend_idx   = (en && !stall) ? last_idx : -1;
    drv_en     = en;
    drv_stall  = stall;
    drv_nibble = nib;
    drv_pc     = pc;
    @(posedge i_clk);
    @(negedge i_clk);
    if (due >= 0) begin
      compare_result(due);
    end else begin
      expect_no_pulse();
    end
  endtask

  task automatic apply_entry(input int idx);
    ins_entry_t        e;
    logic [addr_w-1:0] pc;
    int                k;
    int                r;
    e = table_q[idx];
    for (k = 0; k < e.len; k++) begin
      r = $random(seed) & 3;
      while (r < 2) begin
        // stalled, or not enabled, with junk on the bus
        clock_step(!r[0], !r[0], 4'($random(seed)), addr_w'($random(seed)), -1);
        r = $random(seed) & 3;
      end
      pc = (k == 0) ? e.pc : addr_w'($random(seed));
      clock_step(1'b1, 1'b0, e.nibs[k * 4 +: 4], pc, (k == e.len - 1) ? idx : -1);
    end
  endtask

  initial begin
    int idx;
    build_table();
    table_ready = 1'b1;
    // reset seen at the first three rising edges
    repeat (2) @(negedge i_clk);
    drv_reset = 1'b0;
    @(negedge i_clk);
    expect_no_pulse();
    check_op("o_alu_op", o_alu_op, alu_none);
    compare_flags(10'h0);
    for (idx = 0; idx < table_q.size(); idx++) begin
      apply_entry(idx);
    end
    // last pulse
    clock_step(1'b0, 1'b0, 4'h0, '0, -1);
    $display("Simulation finished: PASS");
    $finish;
  end

  // watchdog, 20 nibbles of 4 cycles per table entry
  initial begin
    wait (table_ready);
    #(table_q.size() * 20 * 4 * 10);
    abort_run("timeout: the instruction table did not finish in the allowed time");
  end

endmodule

/* files.f */
hdl/saturn_dec_pkg.sv
hdl/nibble_bus_if.sv
hdl/decode_sequencer.sv
hdl/system_op_decode.sv
hdl/register_op_decode.sv
hdl/immediate_loader.sv
hdl/saturn_decoder_top.sv
testbench/saturn_decoder_assertions.sv
testbench/saturn_decoder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the decoder testbench with verilator and run it; exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module saturn_decoder_tb \
  -f files.f -o saturn_decoder_sim \
  && ./obj_dir/saturn_decoder_sim \
  || { echo "verilator build or simulation returned an error"; exit 1; }
